// ==== logic/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e    op;
    logic [6:0] addr;
    logic [7:0] wdata;
  } cmd_wr_t;

  typedef struct packed {
    cmd_op_e    op;
    logic [6:0] addr;
    logic [7:0] pad;   // Don't care on the wire
  } cmd_rd_t;

  typedef union packed {
    cmd_wr_t wr;
    cmd_rd_t rd;
  } cmd_word_u;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Status and reply
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic busy;
    logic done;
    logic parity_err;
    logic timeout;
  } bridge_status_t;

  typedef struct packed {
    logic       valid;
    logic       parity_ok;   // Parity and stop both good
    logic [7:0] data;
  } rx_result_t;

  // Register map
  localparam int AXI_ADDR_W = 4;

  localparam logic [AXI_ADDR_W-1:0] REG_CMD    = 4'h0;
  localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'h4;
  localparam logic [AXI_ADDR_W-1:0] REG_RDATA  = 4'h8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== logic/axil_cmd_port.sv ====
module axil_cmd_port import uart_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [31:0]           wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [31:0]           rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  input  bridge_status_t        status,
  input  logic [7:0]            rdata_byte,
  output logic                  cmd_start,
  output cmd_word_u             cmd_word
);

  logic        wr_go;
  logic        wr_hs;
  logic        cmd_hit;
  logic        cmd_take;
  logic        rd_go;
  logic        rd_hs;
  logic [31:0] rd_mux;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign wr_go    = awvalid && wvalid && !awready && !bvalid;
  assign wr_hs    = awready && awvalid && wready && wvalid;
  assign cmd_hit  = (awaddr == REG_CMD);
  assign cmd_take = wr_hs && cmd_hit && !status.busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      cmd_start <= 1'b0;
    end
    else
    begin
      awready   <= wr_go;   // AW and W together
      wready    <= wr_go;
      cmd_start <= cmd_take;
      if (wr_hs)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_hs)
      bresp <= (cmd_hit && status.busy) ? RESP_SLVERR : RESP_OKAY;
    if (cmd_take)
      cmd_word <= wdata[15:0];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign rd_go = arvalid && !arready && !rvalid;
  assign rd_hs = arready && arvalid;
  assign rresp = RESP_OKAY;   // Reads never fail

  always_comb
  begin
    case (araddr)
      REG_STATUS: rd_mux = {28'h0, status};
      REG_RDATA:  rd_mux = {24'h0, rdata_byte};
      default:    rd_mux = 32'h0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      arready <= rd_go;
      if (rd_hs)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_hs)
      rdata <= rd_mux;
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// ==== logic/uart_cmd_sequencer.sv ====
module uart_cmd_sequencer import uart_cmd_pkg::*; #(
  parameter int RESP_TIMEOUT = 64 * 434
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           cmd_start,
  input  cmd_word_u      cmd_word,
  input  logic           tx_busy,
  input  rx_result_t     rx_result,
  output logic           tx_start,
  output logic [7:0]     tx_byte,
  output logic           rx_arm,
  output bridge_status_t status,
  output logic [7:0]     rdata_byte
);

  localparam int TW = $clog2(RESP_TIMEOUT + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_LOW,
    S_SEND_HIGH,
    S_AWAIT_REPLY,
    S_FINISH
  } state_e;

  state_e        state;
  cmd_word_u     cmd_q;
  logic [TW-1:0] wait_cnt;

  // Low byte leaves straight from the port so the start bit follows cmd_start
  always_comb
  begin
    tx_start = 1'b0;
    tx_byte  = {cmd_q.rd.op, cmd_q.rd.addr};
    case (state)
      S_IDLE:
      begin
        tx_start = cmd_start;
        tx_byte  = cmd_word.wr.wdata;   // Pad byte on a read
      end
      S_SEND_LOW:
        tx_start = !tx_busy;   // One idle bit-cell gap of a single clock
      default:
        tx_start = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && cmd_start)
      cmd_q <= cmd_word;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= S_IDLE;
      rx_arm     <= 1'b0;
      wait_cnt   <= '0;
      status     <= '0;
      rdata_byte <= 8'h00;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (cmd_start)
          begin
            state  <= S_SEND_LOW;
            status <= '{busy: 1'b1, done: 1'b0, parity_err: 1'b0, timeout: 1'b0};
          end
        S_SEND_LOW:
          if (!tx_busy)
            state <= S_SEND_HIGH;
        S_SEND_HIGH:
          if (!tx_busy)
          begin
            if (cmd_q.wr.op == OP_WRITE)
            begin
              state       <= S_FINISH;
              status.done <= 1'b1;
            end
            else
            begin
              state    <= S_AWAIT_REPLY;
              rx_arm   <= 1'b1;
              wait_cnt <= TW'(RESP_TIMEOUT - 1);
            end
          end
        S_AWAIT_REPLY:
          if (rx_result.valid)
          begin
            state             <= S_FINISH;
            rx_arm            <= 1'b0;
            status.done       <= 1'b1;
            status.parity_err <= !rx_result.parity_ok;
            rdata_byte        <= rx_result.parity_ok ? rx_result.data : 8'h00;
          end
          else if (wait_cnt == '0)
          begin
            state          <= S_FINISH;   // Remote never answered
            rx_arm         <= 1'b0;
            status.done    <= 1'b1;
            status.timeout <= 1'b1;
            rdata_byte     <= 8'h00;
          end
          else
            wait_cnt <= wait_cnt - 1'b1;
        S_FINISH:
        begin
          state       <= S_IDLE;
          status.busy <= 1'b0;
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  a_no_tx_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy);

endmodule

// ==== logic/uart_tx_framer.sv ====
module uart_tx_framer #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_busy
);

  localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  logic [CW-1:0] baud_cnt;
  logic [3:0]    bit_idx;    // 0 is the start bit, 10 the stop bit
  logic [9:0]    frame_q;    // Stop, parity, data

  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
      frame_q <= {1'b1, ~^tx_byte, tx_byte};
    else if (tx_busy && baud_cnt == CW'(CLKS_PER_BIT - 1))
      frame_q <= {1'b1, frame_q[9:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= 4'd0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx       <= 1'b0;   // Start bit
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= 4'd0;
      end
    end
    else if (baud_cnt == CW'(CLKS_PER_BIT - 1))
    begin
      baud_cnt <= '0;
      if (bit_idx == 4'd10)
      begin
        tx      <= 1'b1;
        tx_busy <= 1'b0;
      end
      else
      begin
        tx      <= frame_q[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end
    else
      baud_cnt <= baud_cnt + 1'b1;
  end

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx);

endmodule

// ==== logic/uart_rx_framer.sv ====
module uart_rx_framer import uart_cmd_pkg::*; #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       rx_arm,
  output rx_result_t rx_result
);

  localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  logic [2:0]    rx_sync;   // Two sync stages plus one for the edge
  logic          rx_s;
  logic          fall;
  logic          active;
  logic [CW-1:0] baud_cnt;
  logic [3:0]    bit_idx;
  logic          mid_bit;
  logic [8:0]    shift_q;   // Parity, then data LSB first

  assign rx_s    = rx_sync[1];
  assign fall    = rx_sync[2] && !rx_sync[1];
  assign mid_bit = active && (baud_cnt == CW'(CLKS_PER_BIT / 2));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_sync <= 3'b111;
    else
      rx_sync <= {rx_sync[1:0], rx};
  end

  // Start bit is skipped, ten samples follow
  always_ff @(posedge clk)
  begin
    if (mid_bit && bit_idx != 4'd0)
      shift_q <= {rx_s, shift_q[8:1]};
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bit timing and result
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active    <= 1'b0;
      baud_cnt  <= '0;
      bit_idx   <= 4'd0;
      rx_result <= '0;
    end
    else
    begin
      rx_result.valid <= 1'b0;
      if (!active)
      begin
        if (rx_arm && fall)
        begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= 4'd0;
        end
      end
      else
      begin
        if (mid_bit && bit_idx == 4'd10)
        begin
          active              <= 1'b0;   // Done at the stop sample
          rx_result.valid     <= 1'b1;
          rx_result.data      <= shift_q[7:0];
          rx_result.parity_ok <= (^shift_q) && rx_s;
        end
        if (baud_cnt == CW'(CLKS_PER_BIT - 1))
        begin
          baud_cnt <= '0;
          bit_idx  <= bit_idx + 1'b1;
        end
        else
          baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    rx_result.valid |=> !rx_result.valid);

endmodule

// ==== logic/uart_cmd_bridge_top.sv ====
module uart_cmd_bridge_top import uart_cmd_pkg::*; #(
  parameter int CLKS_PER_BIT = 434,
  parameter int RESP_TIMEOUT = 64 * CLKS_PER_BIT
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [AXI_ADDR_W-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [31:0]           wdata,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [AXI_ADDR_W-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [31:0]           rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready,
  input  logic                  rx,
  output logic                  tx
);

  bridge_status_t status;
  logic [7:0]     rdata_byte;
  logic           cmd_start;
  cmd_word_u      cmd_word;
  logic           tx_start;
  logic [7:0]     tx_byte;
  logic           tx_busy;
  logic           rx_arm;
  rx_result_t     rx_result;

  axil_cmd_port i_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .status     (status),
    .rdata_byte (rdata_byte),
    .cmd_start  (cmd_start),
    .cmd_word   (cmd_word)
  );

  uart_cmd_sequencer #(
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) i_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_start  (cmd_start),
    .cmd_word   (cmd_word),
    .tx_busy    (tx_busy),
    .rx_result  (rx_result),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .rx_arm     (rx_arm),
    .status     (status),
    .rdata_byte (rdata_byte)
  );

  uart_tx_framer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx_framer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_arm    (rx_arm),
    .rx_result (rx_result)
  );

endmodule

// ==== testbench/uart_device_model.sv ====
module uart_device_model #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic clk,
  input  logic tx,
  output logic rx,
  output int   frames_seen,
  output logic frame_bad
);

  localparam logic [6:0] ADDR_BAD_PARITY = 7'h7F;
  localparam logic [6:0] ADDR_SILENT     = 7'h7E;

  logic [7:0] mem [128];

  // Mid-bit sampling counted from the start edge
  task automatic get_frame(output logic [7:0] data);
    logic [9:0] bits;
    @(negedge tx);
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    for (int i = 0; i < 10; i++)
    begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      bits[i] = tx;   // Data LSB first, parity, stop
    end
    assert ((^bits[8:0]) && bits[9])
    else
    begin
      $display("Device model got frame 0x%03h with a wrong parity or stop bit", bits);
      frame_bad = 1'b1;
    end
    data        = bits[7:0];
    frames_seen = frames_seen + 1;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic flip_parity);
    logic [10:0] frame;
    frame = {1'b1, (~^data) ^ flip_parity, data, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx <= frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command decode and reply
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    logic [7:0] lo;
    logic [7:0] hi;
    rx          = 1'b1;
    frames_seen = 0;
    frame_bad   = 1'b0;
    for (int i = 0; i < 128; i++)
      mem[i] = 8'h00;
    forever
    begin
      get_frame(lo);
      get_frame(hi);
      if (hi[7])
        mem[hi[6:0]] = lo;
      else if (hi[6:0] != ADDR_SILENT)
      begin
        repeat (20 * CLKS_PER_BIT) @(posedge clk);   // Turnaround
        send_frame(mem[hi[6:0]], hi[6:0] == ADDR_BAD_PARITY);
      end
    end
  end

endmodule

// ==== testbench/tb_uart_cmd_bridge.sv ====
module tb_uart_cmd_bridge import uart_cmd_pkg::*; ();

  localparam int CLKS_PER_BIT = 16;
  localparam int RESP_TIMEOUT = 1024;
  localparam int MAX_CYCLES   = 40 * (22 + 20 + 11) * CLKS_PER_BIT + RESP_TIMEOUT + 4000;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [31:0]           wdata;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [31:0]           rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic                  rx;
  logic                  tx;
  int                    frames_seen;
  logic                  frame_bad;
  int                    cycles = 0;
  logic [31:0]           lfsr_q = 32'd69441;
  logic [7:0]            shadow [128];

  always #50 clk = ~clk;

  uart_cmd_bridge_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .RESP_TIMEOUT (RESP_TIMEOUT)
  ) i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .rx      (rx),
    .tx      (tx)
  );

  uart_device_model #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_device (
    .clk         (clk),
    .tx          (tx),
    .rx          (rx),
    .frames_seen (frames_seen),
    .frame_bad   (frame_bad)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checking helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic abort_sim();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
      abort_sim();
    end
  endtask

  a_frames_ok: assert property (@(posedge clk) !frame_bad)
  else
    abort_sim();

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES)
    begin
      $display("Run did not finish within %0d cycles, the bridge seems stuck", MAX_CYCLES);
      abort_sim();
    end
  end

  // Galois form, one step per bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] v);
    v = 8'h00;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[6:0], lfsr_q[0]};
    end
  endtask

  function automatic bridge_status_t done_status(input logic perr, input logic tmo);
    return '{busy: 1'b0, done: 1'b1, parity_err: perr, timeout: tmo};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite master
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    do
      @(posedge clk);
    while (!awready);
    check_value("write wready", 1'b1, wready);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    do
      @(posedge clk);
    while (!bvalid);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do
      @(posedge clk);
    while (!arready);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    do
      @(posedge clk);
    while (!rvalid);
    data = rdata;
    check_value("read rresp", RESP_OKAY, rresp);
    rready <= 1'b0;
  endtask

  task automatic wait_idle(output bridge_status_t st);
    logic [31:0] word;
    do
      axi_read(REG_STATUS, word);
    while (word[3]);   // Busy
    st = bridge_status_t'(word[3:0]);
  endtask

  // Every command costs exactly two frames on the wire
  task automatic run_cmd(input string name, input cmd_word_u c,
                         output bridge_status_t st, output logic [7:0] rd);
    logic [1:0]  resp;
    logic [31:0] word;
    int          frames0;
    frames0 = frames_seen;
    axi_write(REG_CMD, {16'h0, c}, resp);
    check_value({name, " bresp"}, RESP_OKAY, resp);
    wait_idle(st);
    check_value({name, " frames"}, frames0 + 2, frames_seen);
    axi_read(REG_RDATA, word);
    rd = word[7:0];
  endtask

  task automatic do_write(input string name, input logic [6:0] addr, input logic [7:0] data);
    cmd_word_u      c;
    bridge_status_t st;
    logic [7:0]     rd;
    c.wr.op    = OP_WRITE;
    c.wr.addr  = addr;
    c.wr.wdata = data;
    run_cmd(name, c, st, rd);
    check_value({name, " status"}, done_status(1'b0, 1'b0), st);
    shadow[addr] = data;
  endtask

  task automatic do_read(input string name, input logic [6:0] addr, input logic [7:0] pad,
                         input logic [7:0] exp, input logic perr, input logic tmo);
    cmd_word_u      c;
    bridge_status_t st;
    logic [7:0]     rd;
    c.rd.op   = OP_READ;
    c.rd.addr = addr;
    c.rd.pad  = pad;
    run_cmd(name, c, st, rd);
    check_value({name, " status"}, done_status(perr, tmo), st);
    check_value({name, " rdata"}, exp, rd);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    cmd_word_u      c;
    bridge_status_t st;
    logic [1:0]     resp;
    logic [31:0]    word;
    logic [7:0]     op_bit;
    logic [7:0]     rnd_addr;
    logic [7:0]     rnd_data;
    logic [6:0]     addr;
    int             frames0;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < 128; i++)
      shadow[i] = 8'h00;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    check_value("reset tx", 1'b1, tx);
    check_value("reset bvalid", 1'b0, bvalid);
    check_value("reset rvalid", 1'b0, rvalid);
    axi_read(REG_STATUS, word);
    check_value("reset status", 32'h0, word);

    do_write("write 0x12", 7'h12, 8'hA5);
    do_read("read 0x12", 7'h12, 8'h00, 8'hA5, 1'b0, 1'b0);

    for (int n = 0; n < 30; n++)
    begin
      rand_bits(1, op_bit);
      rand_bits(7, rnd_addr);
      rand_bits(8, rnd_data);
      addr = 7'(int'(rnd_addr) % 126);   // Keep clear of 0x7E and 0x7F
      if (op_bit[0])
        do_write("random write", addr, rnd_data);
      else
        do_read("random read", addr, rnd_data, shadow[addr], 1'b0, 1'b0);
    end

    // Stored byte and last read are nonzero before each bad reply
    do_write("parity prep", 7'h7F, 8'h5A);
    do_write("reply prep", 7'h40, 8'hC6);
    do_read("before parity", 7'h40, 8'h00, 8'hC6, 1'b0, 1'b0);
    do_read("parity error", 7'h7F, 8'h00, 8'h00, 1'b1, 1'b0);
    do_read("before timeout", 7'h40, 8'h00, 8'hC6, 1'b0, 1'b0);
    do_read("reply timeout", 7'h7E, 8'h00, 8'h00, 1'b0, 1'b1);

    // Second command lands while the first is still on the wire
    c.wr.op    = OP_WRITE;
    c.wr.addr  = 7'h33;
    c.wr.wdata = 8'h3C;
    frames0    = frames_seen;
    axi_write(REG_CMD, {16'h0, c}, resp);
    check_value("busy first bresp", RESP_OKAY, resp);
    axi_read(REG_STATUS, word);
    check_value("busy flag", 1'b1, word[3]);
    c.wr.addr  = 7'h34;
    c.wr.wdata = 8'hC3;
    axi_write(REG_CMD, {16'h0, c}, resp);
    check_value("busy reject bresp", RESP_SLVERR, resp);
    wait_idle(st);
    check_value("busy status", done_status(1'b0, 1'b0), st);
    check_value("busy frames", frames0 + 2, frames_seen);
    shadow[7'h33] = 8'h3C;
    do_read("after busy 0x33", 7'h33, 8'h00, 8'h3C, 1'b0, 1'b0);
    do_read("after busy 0x34", 7'h34, 8'h00, shadow[7'h34], 1'b0, 1'b0);

    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/uart_cmd_pkg.sv
logic/axil_cmd_port.sv
logic/uart_cmd_sequencer.sv
logic/uart_tx_framer.sv
logic/uart_rx_framer.sv
logic/uart_cmd_bridge_top.sv
testbench/uart_device_model.sv
testbench/tb_uart_cmd_bridge.sv

// ==== Bender.yml ====
package:
  name: uart_cmd_bridge

sources:
  - files:
      - logic/uart_cmd_pkg.sv
      - logic/axil_cmd_port.sv
      - logic/uart_cmd_sequencer.sv
      - logic/uart_tx_framer.sv
      - logic/uart_rx_framer.sv
      - logic/uart_cmd_bridge_top.sv
  - target: test
    files:
      - testbench/uart_device_model.sv
      - testbench/tb_uart_cmd_bridge.sv
